//--- design/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width in bits.
`define LSU_XLEN 32

// first byte address of the sram window.
// keep it aligned to the window size.
`define LSU_MEM_BASE 32'h8000_0000

// sram depth in words, a power of two.
`define LSU_MEM_WORDS 256

`endif

//--- design/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [`LSU_XLEN-1:0]   addr_t;
    typedef logic [`LSU_XLEN/8-1:0] strb_t;
    typedef logic [1:0]             axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // access width of a load or store.
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_WR_REQ,
        ST_WR_RESP
    } lsu_state_t;

endpackage

//--- design/axi_mem_if.sv
interface axi_mem_if
    import lsu_pkg::*;
();

    // write address and data.
    logic      awvalid;
    logic      awready;
    addr_t     awaddr;
    logic      wvalid;
    logic      wready;
    word_t     wdata;
    strb_t     wstrb;

    // write response.
    logic      bvalid;
    logic      bready;
    axi_resp_t bresp;

    // read address and data.
    logic      arvalid;
    logic      arready;
    addr_t     araddr;
    logic      rvalid;
    logic      rready;
    word_t     rdata;
    axi_resp_t rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

//--- design/lsu_ctrl.sv
module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  logic       req_write,
    input  mem_size_t  req_size,
    input  logic       req_signed,
    input  addr_t      req_addr,
    input  word_t      req_wdata,
    output logic       busy,
    output logic       resp_valid,
    output word_t      resp_rdata,
    output logic       resp_fault,
    output mem_size_t  size_q,
    output logic [1:0] offset_q,
    output word_t      wdata_q,
    input  word_t      wdata_aligned,
    input  strb_t      wstrb,
    output logic       signed_q,
    input  word_t      load_value,
    axi_mem_if.master  axi
);

    lsu_state_t state;
    addr_t      addr_q;
    logic       awvalid_q;
    logic       wvalid_q;
    logic       aw_done;
    logic       w_done;

    assign busy     = (state != ST_IDLE);
    assign offset_q = addr_q[1:0];

    // read channels.
    assign axi.arvalid = (state == ST_RD_ADDR);
    assign axi.araddr  = addr_q;
    assign axi.rready  = (state == ST_RD_DATA);

    // write channels; data comes back already aligned.
    assign axi.awvalid = awvalid_q;
    assign axi.awaddr  = addr_q;
    assign axi.wvalid  = wvalid_q;
    assign axi.wdata   = wdata_aligned;
    assign axi.wstrb   = wstrb;
    assign axi.bready  = (state == ST_WR_RESP);

    // aw and w may complete in different cycles.
    assign aw_done = !awvalid_q || axi.awready;
    assign w_done  = !wvalid_q || axi.wready;

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            awvalid_q  <= 1'b0;
            wvalid_q   <= 1'b0;
            size_q     <= SZ_WORD;
            signed_q   <= 1'b0;
            resp_valid <= 1'b0;
            resp_rdata <= '0;
            resp_fault <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        size_q   <= req_size;
                        signed_q <= req_signed;
                        if (req_write) begin
                            awvalid_q <= 1'b1;
                            wvalid_q  <= 1'b1;
                            state     <= ST_WR_REQ;
                        end else begin
                            state <= ST_RD_ADDR;
                        end
                    end
                end
                ST_RD_ADDR: begin
                    if (axi.arready) begin
                        state <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (axi.rvalid) begin
                        resp_valid <= 1'b1;
                        resp_rdata <= load_value;
                        resp_fault <= (axi.rresp != RESP_OKAY);
                        state      <= ST_IDLE;
                    end
                end
                ST_WR_REQ: begin
                    if (axi.awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (axi.wready) begin
                        wvalid_q <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (axi.bvalid) begin
                        resp_valid <= 1'b1;
                        resp_rdata <= '0;
                        resp_fault <= (axi.bresp != RESP_OKAY);
                        state      <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // write valids hold until the slave takes them.
    a_awvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axi.awvalid && !axi.awready |=> axi.awvalid);
    a_wvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axi.wvalid && !axi.wready |=> axi.wvalid);

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid);

endmodule

//--- design/lsu_store_align.sv
module lsu_store_align
    import lsu_pkg::*;
(
    input  mem_size_t  size,
    input  logic [1:0] offset,
    input  word_t      wdata,
    output word_t      wdata_aligned,
    output strb_t      wstrb
);

    strb_t base_strb;

    // move the low bytes up into their lane.
    assign wdata_aligned = wdata << {offset, 3'b000};

    always_comb begin
        case (size)
            SZ_BYTE: base_strb = strb_t'(4'b0001);
            SZ_HALF: base_strb = strb_t'(4'b0011);
            SZ_WORD: base_strb = strb_t'(4'b1111);
            default: base_strb = '0;
        endcase
    end

    assign wstrb = base_strb << offset;

endmodule

//--- design/lsu_load_extract.sv
`include "lsu_params.svh"

module lsu_load_extract
    import lsu_pkg::*;
(
    input  mem_size_t  size,
    input  logic [1:0] offset,
    input  logic       is_signed,
    input  word_t      rdata,
    output word_t      load_value
);

    word_t shifted;
    logic  fill_b;
    logic  fill_h;

    // bring the addressed lane down to bit zero.
    assign shifted = rdata >> {offset, 3'b000};

    assign fill_b = is_signed & shifted[7];
    assign fill_h = is_signed & shifted[15];

    always_comb begin
        case (size)
            SZ_BYTE: load_value = {{(`LSU_XLEN-8){fill_b}}, shifted[7:0]};
            SZ_HALF: load_value = {{(`LSU_XLEN-16){fill_h}}, shifted[15:0]};
            SZ_WORD: load_value = shifted;
            default: load_value = shifted;
        endcase
    end

    always_comb begin
        a_size_known: assert (size inside {SZ_BYTE, SZ_HALF, SZ_WORD})
            else $error("load size %0d has no encoding", size);
    end

endmodule

//--- design/axi_sram.sv
`include "lsu_params.svh"

module axi_sram
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    axi_mem_if.slave axi
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    word_t mem [`LSU_MEM_WORDS];

    logic             rdy_q;
    logic             aw_got;
    logic             w_got;
    logic             idle;
    logic             ar_hs;
    logic             aw_hs;
    logic             w_hs;
    logic             wr_fire;
    addr_t            awaddr_q;
    word_t            wdata_q;
    strb_t            wstrb_q;
    addr_t            wr_addr;
    word_t            wr_data;
    strb_t            wr_strb;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    function automatic logic in_window(addr_t a);
        addr_t rel;
        // below the base wraps to a large offset.
        rel = a - addr_t'(`LSU_MEM_BASE);
        return rel < addr_t'(`LSU_MEM_WORDS * 4);
    endfunction

    // one transaction at a time.
    assign idle        = !axi.rvalid && !axi.bvalid;
    assign axi.arready = rdy_q && idle && !aw_got && !w_got;
    assign axi.awready = rdy_q && idle && !aw_got;
    assign axi.wready  = rdy_q && idle && !w_got;

    assign ar_hs = axi.arvalid && axi.arready;
    assign aw_hs = axi.awvalid && axi.awready;
    assign w_hs  = axi.wvalid && axi.wready;

    // aw and w may arrive together or apart.
    assign wr_addr = aw_got ? awaddr_q : axi.awaddr;
    assign wr_data = w_got ? wdata_q : axi.wdata;
    assign wr_strb = w_got ? wstrb_q : axi.wstrb;
    assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs);

    assign rd_idx = axi.araddr[IDX_W+1:2];
    assign wr_idx = wr_addr[IDX_W+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdy_q      <= 1'b0;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            axi.rvalid <= 1'b0;
            axi.bvalid <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
            if (ar_hs) begin
                axi.rvalid <= 1'b1;
            end else if (axi.rvalid && axi.rready) begin
                axi.rvalid <= 1'b0;
            end
            if (wr_fire) begin
                aw_got     <= 1'b0;
                w_got      <= 1'b0;
                axi.bvalid <= 1'b1;
            end else begin
                if (aw_hs) begin
                    aw_got <= 1'b1;
                end
                if (w_hs) begin
                    w_got <= 1'b1;
                end
                if (axi.bvalid && axi.bready) begin
                    axi.bvalid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awaddr_q <= axi.awaddr;
        end
        if (w_hs) begin
            wdata_q <= axi.wdata;
            wstrb_q <= axi.wstrb;
        end
        if (ar_hs) begin
            axi.rdata <= in_window(axi.araddr) ? mem[rd_idx] : '0;
            axi.rresp <= in_window(axi.araddr) ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_fire) begin
            axi.bresp <= in_window(wr_addr) ? RESP_OKAY : RESP_SLVERR;
            if (in_window(wr_addr)) begin
                for (int b = 0; b < `LSU_XLEN/8; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end
        end
    end

    // the master never opens a read and a write together.
    a_no_mixed_req: assert property (@(posedge clk) disable iff (rst)
        !(axi.arvalid && axi.awvalid));

endmodule

//--- design/lsu_top.sv
module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  logic      req_write,
    input  mem_size_t req_size,
    input  logic      req_signed,
    input  addr_t     req_addr,
    input  word_t     req_wdata,
    output logic      busy,
    output logic      resp_valid,
    output word_t     resp_rdata,
    output logic      resp_fault
);

    mem_size_t  size_q;
    logic [1:0] offset_q;
    word_t      wdata_q;
    word_t      wdata_aligned;
    strb_t      wstrb;
    logic       signed_q;
    word_t      load_value;

    axi_mem_if mem_bus ();

    lsu_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_size      (req_size),
        .req_signed    (req_signed),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .busy          (busy),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_fault    (resp_fault),
        .size_q        (size_q),
        .offset_q      (offset_q),
        .wdata_q       (wdata_q),
        .wdata_aligned (wdata_aligned),
        .wstrb         (wstrb),
        .signed_q      (signed_q),
        .load_value    (load_value),
        .axi           (mem_bus.master)
    );

    lsu_store_align u_align (
        .size          (size_q),
        .offset        (offset_q),
        .wdata         (wdata_q),
        .wdata_aligned (wdata_aligned),
        .wstrb         (wstrb)
    );

    // read data is taken straight off the bus.
    lsu_load_extract u_extract (
        .size       (size_q),
        .offset     (offset_q),
        .is_signed  (signed_q),
        .rdata      (mem_bus.rdata),
        .load_value (load_value)
    );

    axi_sram u_sram (
        .clk (clk),
        .rst (rst),
        .axi (mem_bus.slave)
    );

endmodule

//--- tb/tb_lsu_top.sv
`include "lsu_params.svh"

module tb_lsu_top
    import lsu_pkg::*;
();

    localparam int    WIN_BYTES = `LSU_MEM_WORDS * 4;
    localparam int    WIN_BITS  = $clog2(WIN_BYTES);
    localparam addr_t BASE      = `LSU_MEM_BASE;

    logic      clk;
    logic      rst;
    logic      req_valid;
    logic      req_write;
    mem_size_t req_size;
    logic      req_signed;
    addr_t     req_addr;
    word_t     req_wdata;
    logic      busy;
    logic      resp_valid;
    word_t     resp_rdata;
    logic      resp_fault;

    // byte image of the sram window.
    logic [7:0]  model [WIN_BYTES];
    logic [31:0] lfsr_q = 32'd31;

    lsu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form with one output bit per step.
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic in_window(addr_t a);
        return (a - BASE) < addr_t'(WIN_BYTES);
    endfunction

    // little endian with lanes picked by the low address bits.
    function automatic word_t predict_load(addr_t a, mem_size_t sz, logic sgn);
        logic [WIN_BITS-1:0] i;
        word_t               v;
        if (!in_window(a)) begin
            return '0;
        end
        i = WIN_BITS'(a - BASE);
        v = '0;
        for (int b = 3; b >= 0; b--) begin
            v = {v[23:0], model[i + WIN_BITS'(b)]};
        end
        case (sz)
            SZ_BYTE: v = {{24{sgn & v[7]}}, v[7:0]};
            SZ_HALF: v = {{16{sgn & v[15]}}, v[15:0]};
            default: v = v;
        endcase
        return v;
    endfunction

    function automatic void model_store(addr_t a, mem_size_t sz, word_t d);
        logic [WIN_BITS-1:0] i;
        int                  nb;
        i = WIN_BITS'(a - BASE);
        nb = (sz == SZ_BYTE) ? 1 : (sz == SZ_HALF) ? 2 : 4;
        for (int b = 0; b < nb; b++) begin
            model[i + WIN_BITS'(b)] = d[8*b +: 8];
        end
    endfunction

    task automatic check_value(string name, word_t got, word_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Result: FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic send_req(logic wr, mem_size_t sz, logic sgn, addr_t a, word_t d);
        @(negedge clk);
        req_valid  = 1'b1;
        req_write  = wr;
        req_size   = sz;
        req_signed = sgn;
        req_addr   = a;
        req_wdata  = d;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic access(logic wr, mem_size_t sz, logic sgn, addr_t a, word_t d);
        word_t expected;
        int    cycles;
        expected = wr ? '0 : predict_load(a, sz, sgn);
        send_req(wr, sz, sgn, a, d);
        check_value("busy", word_t'(busy), 32'd1);
        cycles = 0;
        while (!resp_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > 50) begin
                $display("no response from the LSU for address 0x%h", a);
                $display("Result: FAILED");
                $fatal(1, "response timeout");
            end
        end
        // busy drops together with the response strobe.
        check_value("busy", word_t'(busy), '0);
        check_value("resp_rdata", resp_rdata, expected);
        check_value("resp_fault", word_t'(resp_fault), word_t'(!in_window(a)));
        if (wr && in_window(a)) begin
            model_store(a, sz, d);
        end
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_value("busy", word_t'(busy), '0);
            check_value("resp_valid", word_t'(resp_valid), '0);
        end
    endtask

    task automatic fill_memory();
        addr_t a;
        for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
            a = BASE + addr_t'(w * 4);
            access(1'b1, SZ_WORD, 1'b0, a, a ^ {a[15:0], a[31:16]} ^ 32'h5ac3_96e1);
        end
    endtask

    task automatic test_word_roundtrip();
        word_t d;
        d = rand_bits(32);
        access(1'b1, SZ_WORD, 1'b0, BASE + 32'h40, d);
        access(1'b0, SZ_WORD, 1'b0, BASE + 32'h40, '0);
        check_value("resp_rdata", resp_rdata, d);
    endtask

    task automatic test_partial_stores();
        for (int o = 0; o < 4; o++) begin
            access(1'b1, SZ_BYTE, 1'b0, BASE + 32'h80 + addr_t'(o), rand_bits(32));
            access(1'b0, SZ_WORD, 1'b0, BASE + 32'h80, '0);
        end
        for (int o = 0; o < 4; o += 2) begin
            access(1'b1, SZ_HALF, 1'b0, BASE + 32'h84 + addr_t'(o), rand_bits(32));
            access(1'b0, SZ_WORD, 1'b0, BASE + 32'h84, '0);
        end
    endtask

    task automatic test_extension();
        access(1'b1, SZ_WORD, 1'b0, BASE + 32'hc0, 32'h7f80_01ff);
        access(1'b1, SZ_WORD, 1'b0, BASE + 32'hc4, 32'h8000_7fff);
        for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < 8; o++) begin
                access(1'b0, SZ_BYTE, s[0], BASE + 32'hc0 + addr_t'(o), '0);
            end
            for (int o = 0; o < 8; o += 2) begin
                access(1'b0, SZ_HALF, s[0], BASE + 32'hc0 + addr_t'(o), '0);
            end
        end
        access(1'b0, SZ_BYTE, 1'b1, BASE + 32'hc0, '0);
        check_value("resp_rdata", resp_rdata, 32'hffff_ffff);
        access(1'b0, SZ_HALF, 1'b0, BASE + 32'hc6, '0);
        check_value("resp_rdata", resp_rdata, 32'h0000_8000);
    endtask

    task automatic test_out_of_window();
        access(1'b0, SZ_WORD, 1'b0, BASE + addr_t'(WIN_BYTES), '0);
        check_value("resp_fault", word_t'(resp_fault), 32'd1);
        // just below the base aliases the last word if the window is ignored.
        access(1'b1, SZ_WORD, 1'b0, BASE - 32'd4, 32'hdead_beef);
        access(1'b0, SZ_WORD, 1'b0, BASE + addr_t'(WIN_BYTES - 4), '0);
        access(1'b0, SZ_WORD, 1'b0, BASE, '0);
    endtask

    task automatic test_random();
        logic      wr;
        logic      sgn;
        mem_size_t sz;
        word_t     raw;
        addr_t     a;
        for (int n = 0; n < 200; n++) begin
            wr  = lfsr_bit();
            sgn = lfsr_bit();
            raw = rand_bits(2);
            sz  = (raw == 32'd3) ? SZ_WORD : mem_size_t'(raw[1:0]);
            a   = BASE + rand_bits(WIN_BITS);
            if (sz == SZ_HALF) begin
                a[0] = 1'b0;
            end
            if (sz == SZ_WORD) begin
                a[1:0] = 2'b00;
            end
            // about one in eight lands past the window.
            if (rand_bits(3) == 32'd0) begin
                a = a + addr_t'(WIN_BYTES);
            end
            access(wr, sz, sgn, a, rand_bits(32));
        end
    endtask

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_size   = SZ_WORD;
        req_signed = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_reset_idle();
        fill_memory();
        test_word_roundtrip();
        test_partial_stores();
        test_extension();
        test_out_of_window();
        test_random();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- lsu_sys.f
+incdir+design
design/lsu_pkg.sv
design/axi_mem_if.sv
design/lsu_ctrl.sv
design/lsu_store_align.sv
design/lsu_load_extract.sv
design/axi_sram.sv
design/lsu_top.sv
tb/tb_lsu_top.sv

//--- Makefile
TOP := tb_lsu_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f lsu_sys.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
